// ==== tb.f ====
+incdir+.
opm_pkg.sv
opm_beat_if.sv
opm_ctrl.sv
opm_data_buffer.sv
opm_idb_writer.sv
opm_top.sv
tb_opm_top.sv

// ==== Bender.yml ====
package:
  name: opm

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - opm_pkg.sv
      - opm_beat_if.sv
      - opm_ctrl.sv
      - opm_data_buffer.sv
      - opm_idb_writer.sv
      - opm_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_opm_top.sv

// ==== tb_opm_top.sv ====
`timescale 1ns/1ns
`include "opm_defs.svh"

module tb_opm_top;

    localparam int N_RUNS   = 12;
    // eight FIFO entries plus the output register
    localparam int DDB_HELD = `OPM_DDB_DEPTH + 1;

    typedef struct packed {
        opm_pkg::lane_vec_t data;
        logic               last;
    } out_beat_t;

    typedef struct packed {
        opm_pkg::lane_mask_t mask;
        opm_pkg::idb_addr_t  addr;
        opm_pkg::lane_vec_t  data;
    } idb_wr_t;

    logic                clk;
    logic                rstn;
    logic                cfg_start_i;
    opm_pkg::stage_t     cfg_stage_i;
    opm_pkg::beat_cnt_t  cfg_count_i;
    opm_pkg::m_cnt_t     cfg_m_i;
    opm_pkg::n1_cnt_t    cfg_n1_i;
    logic                valid_i;
    opm_pkg::lane_vec_t  act_i;
    opm_pkg::act_t       acc_i;
    logic                tready_i;
    logic                ready_o;
    logic                finish_o;
    logic                tvalid_o;
    logic                tlast_o;
    opm_pkg::lane_vec_t  tdata_o;
    opm_pkg::lane_mask_t idb_wr_en_o;
    opm_pkg::idb_addr_t  idb_addr_o;
    opm_pkg::lane_vec_t  idb_din_o;

    opm_pkg::stage_t stage_a [N_RUNS];
    int              count_a [N_RUNS];
    int              m_a [N_RUNS];
    int              n1_a [N_RUNS];
    int              stall_a [N_RUNS];
    bit              tready_pat [];
    int              limit;
    int              cycles;
    int              stall_cnt;
    bit              mon_on;

    // reference model state
    out_beat_t       out_q [$];
    idb_wr_t         idb_q [$];
    opm_pkg::stage_t cur_stage;
    int              cur_count;
    int              cur_m;
    int              cur_n1;
    int              mdl_idx;
    int              mdl_m;
    int              mdl_n1;
    bit              exp_finish;
    bit              stalled;
    bit              full_seen;

    opm_top opm_top_inst (.*);

    always #4 clk = ~clk;

    task automatic stop_with_failure();
        $display("CHECKS FAILED");
        $fatal(1, "testbench stopped");
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        stop_with_failure();
    endtask

    task automatic check_beat(input string name, input opm_pkg::lane_vec_t exp_data,
                              input logic exp_last, input opm_pkg::lane_vec_t act_data,
                              input logic act_last);
        if (exp_data !== act_data || exp_last !== act_last) begin
            $display("Error %s: expected data %h last %b, actual data %h last %b",
                     name, exp_data, exp_last, act_data, act_last);
            stop_with_failure();
        end
    endtask

    task automatic check_idb(input string name, input opm_pkg::lane_mask_t exp_mask,
                             input opm_pkg::idb_addr_t exp_addr,
                             input opm_pkg::lane_vec_t exp_data,
                             input opm_pkg::lane_mask_t act_mask,
                             input opm_pkg::idb_addr_t act_addr,
                             input opm_pkg::lane_vec_t act_data);
        // address and data only matter when some lane writes
        if (act_mask !== exp_mask ||
            (exp_mask != '0 && (act_addr !== exp_addr || act_data !== exp_data))) begin
            $display("Error %s: expected mask %b addr %0d data %h, actual mask %b addr %0d data %h",
                     name, exp_mask, exp_addr, exp_data, act_mask, act_addr, act_data);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        if (exp_val !== act_val) begin
            $display("Error %s: expected %b, actual %b", name, exp_val, act_val);
            stop_with_failure();
        end
    endtask

    function automatic bit is_streaming(input opm_pkg::stage_t s);
        return s inside {opm_pkg::STAGE_FP, opm_pkg::STAGE_BPDW, opm_pkg::STAGE_PU};
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: the runs did not complete within %0d cycles", limit);
            stop_with_failure();
        end
    end

    // tready follows a pattern made at time zero, forced low during a stall window
    always @(posedge clk) begin
        #1;
        if (stall_cnt > 0) begin
            tready_i = 1'b0;
            stall_cnt = stall_cnt - 1;
        end else if (cycles < limit) begin
            tready_i = tready_pat[cycles];
        end
    end

    // all transfers are decided by the values seen at the falling edge
    always @(negedge clk) begin : monitor
        out_beat_t eb;
        idb_wr_t   ew;
        bit        end_event;
        if (mon_on) begin
            end_event = 1'b0;
            check_flag("finish", exp_finish, finish_o);
            if (exp_finish) begin
                check_flag("ready while idle", 1'b0, ready_o);
            end
            // IDB write registered on the previous edge
            if (idb_q.size() > 0) begin
                ew = idb_q.pop_front();
                check_idb("idb write", ew.mask, ew.addr, ew.data,
                          idb_wr_en_o, idb_addr_o, idb_din_o);
            end else begin
                check_idb("idb quiet", '0, '0, '0, idb_wr_en_o, idb_addr_o, idb_din_o);
            end
            if (!is_streaming(cur_stage)) begin
                check_flag("tvalid in idb stage", 1'b0, tvalid_o);
            end
            if (stalled) begin
                check_flag("tvalid while stalled", 1'b1, tvalid_o);
            end
            stalled = tvalid_o && !tready_i;
            if (stalled && out_q.size() > 0) begin
                check_beat("stalled beat", out_q[0].data, out_q[0].last, tdata_o, tlast_o);
            end
            if (out_q.size() >= DDB_HELD) begin
                full_seen = 1'b1;
                check_flag("ready while full", 1'b0, ready_o);
            end
            if (tvalid_o && tready_i) begin
                if (out_q.size() == 0) begin
                    abort_run("an output beat was sent with no beat expected");
                end
                eb = out_q.pop_front();
                check_beat("stream beat", eb.data, eb.last, tdata_o, tlast_o);
                if (eb.last) begin
                    end_event = 1'b1;
                end
            end
            if (valid_i && ready_o) begin
                if (mdl_idx > cur_count) begin
                    abort_run("a beat was accepted after the last beat of the run");
                end
                if (is_streaming(cur_stage)) begin
                    eb.data = act_i;
                    eb.last = (mdl_idx == cur_count);
                    out_q.push_back(eb);
                end
                ew.data = act_i;
                case (cur_stage)
                    opm_pkg::STAGE_FP: begin
                        ew.mask = '1;
                        ew.addr = opm_pkg::idb_addr_t'(`OPM_IDB_A_BASE + mdl_idx);
                        idb_q.push_back(ew);
                    end
                    opm_pkg::STAGE_BPDZ: begin
                        ew.mask = '1;
                        ew.addr = opm_pkg::idb_addr_t'(`OPM_IDB_DZ_BASE + mdl_idx);
                        idb_q.push_back(ew);
                    end
                    opm_pkg::STAGE_BPDA: begin
                        ew.mask = opm_pkg::lane_mask_t'(1 << (mdl_n1 % `OPM_NUM_PE));
                        ew.addr = opm_pkg::idb_addr_t'(`OPM_IDB_DA_BASE
                                  + (mdl_n1 / `OPM_NUM_PE) * `OPM_MAX_M + mdl_m);
                        ew.data = {`OPM_NUM_PE{acc_i}};
                        idb_q.push_back(ew);
                    end
                    default: begin
                    end
                endcase
                if (!is_streaming(cur_stage) && mdl_idx == cur_count) begin
                    end_event = 1'b1;
                end
                mdl_idx++;
                // m wraps at cfg m and carries into n1
                if (mdl_m == cur_m) begin
                    mdl_m  = 0;
                    mdl_n1 = (mdl_n1 == cur_n1) ? 0 : mdl_n1 + 1;
                end else begin
                    mdl_m++;
                end
            end
            if (cfg_start_i && finish_o) begin
                if (out_q.size() != 0 || idb_q.size() != 0) begin
                    abort_run("a new run started with expected beats still pending");
                end
                cur_stage  = cfg_stage_i;
                cur_count  = cfg_count_i;
                cur_m      = cfg_m_i;
                cur_n1     = cfg_n1_i;
                mdl_idx    = 0;
                mdl_m      = 0;
                mdl_n1     = 0;
                exp_finish = 1'b0;
            end
            if (end_event) begin
                exp_finish = 1'b1;
            end
        end
    end

    initial begin : driver
        int  total;
        int  pct;
        int  gap;
        bit  took;
        clk = 1'b0;
        rstn = 1'b0;
        cfg_start_i = 1'b0;
        cfg_stage_i = opm_pkg::STAGE_FP;
        cfg_count_i = '0;
        cfg_m_i = '0;
        cfg_n1_i = '0;
        valid_i = 1'b0;
        act_i = '0;
        acc_i = '0;
        tready_i = 1'b0;
        cycles = 0;
        stall_cnt = 0;
        mon_on = 1'b0;
        cur_stage = opm_pkg::STAGE_FP;
        exp_finish = 1'b1;
        stalled = 1'b0;
        full_seen = 1'b0;
        void'($urandom(66174));

        // first five runs cover every stage, the rest are random
        total = 0;
        for (int r = 0; r < N_RUNS; r++) begin
            case (r)
                0:       stage_a[r] = opm_pkg::STAGE_FP;
                1:       stage_a[r] = opm_pkg::STAGE_BPDW;
                2:       stage_a[r] = opm_pkg::STAGE_PU;
                3:       stage_a[r] = opm_pkg::STAGE_BPDZ;
                4:       stage_a[r] = opm_pkg::STAGE_BPDA;
                default: stage_a[r] = opm_pkg::stage_t'($urandom % 5);
            endcase
            count_a[r] = $urandom % 64;
            stall_a[r] = 0;
            if (r == 1 || r == 2) begin
                count_a[r] = 20 + $urandom % 40;
                stall_a[r] = 40;
            end
            m_a[r] = $urandom % `OPM_MAX_M;
            n1_a[r] = $urandom % `OPM_MAX_N;
            total += count_a[r] + 1;
        end
        limit = total * 6 + 200;
        tready_pat = new[limit];
        pct = 50;
        for (int c = 0; c < limit; c++) begin
            if (c % 64 == 0) begin
                pct = 30 + $urandom % 71;
            end
            tready_pat[c] = ($urandom % 100) < pct;
        end

        repeat (5) @(posedge clk);
        #1 rstn = 1'b1;
        @(negedge clk);
        check_flag("tvalid after reset", 1'b0, tvalid_o);
        check_flag("ready after reset", 1'b0, ready_o);
        check_flag("finish after reset", 1'b1, finish_o);
        check_idb("idb after reset", '0, '0, '0, idb_wr_en_o, idb_addr_o, idb_din_o);
        @(posedge clk);
        #1 mon_on = 1'b1;

        for (int r = 0; r < N_RUNS; r++) begin
            @(negedge clk);
            stall_cnt = stall_a[r];
            @(posedge clk);
            #1;
            cfg_stage_i = stage_a[r];
            cfg_count_i = opm_pkg::beat_cnt_t'(count_a[r]);
            cfg_m_i = opm_pkg::m_cnt_t'(m_a[r]);
            cfg_n1_i = opm_pkg::n1_cnt_t'(n1_a[r]);
            cfg_start_i = 1'b1;
            @(posedge clk);
            #1 cfg_start_i = 1'b0;
            for (int i = 0; i <= count_a[r]; i++) begin
                gap = $urandom % 3;
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
                valid_i = 1'b1;
                act_i = {$urandom, $urandom};
                acc_i = opm_pkg::act_t'($urandom);
                took = 1'b0;
                while (!took) begin
                    @(negedge clk);
                    took = ready_o;
                    @(posedge clk);
                    #1;
                end
                valid_i = 1'b0;
            end
            // one more beat stays on offer while the run drains
            valid_i = 1'b1;
            while (!finish_o) begin
                @(posedge clk);
                #1;
            end
            valid_i = 1'b0;
        end

        repeat (3) begin
            @(posedge clk);
            #1;
        end
        if (full_seen && out_q.size() == 0 && idb_q.size() == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("the FIFO never filled, or expected beats were left over");
            stop_with_failure();
        end
    end

endmodule

// ==== opm_top.sv ====
`timescale 1ns/1ns

module opm_top (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 cfg_start_i,
    input  opm_pkg::stage_t      cfg_stage_i,
    input  opm_pkg::beat_cnt_t   cfg_count_i,
    input  opm_pkg::m_cnt_t      cfg_m_i,
    input  opm_pkg::n1_cnt_t     cfg_n1_i,
    input  logic                 valid_i,
    input  opm_pkg::lane_vec_t   act_i,
    input  opm_pkg::act_t        acc_i,
    input  logic                 tready_i,
    output logic                 ready_o,
    output logic                 finish_o,
    output logic                 tvalid_o,
    output logic                 tlast_o,
    output opm_pkg::lane_vec_t   tdata_o,
    output opm_pkg::lane_mask_t  idb_wr_en_o,
    output opm_pkg::idb_addr_t   idb_addr_o,
    output opm_pkg::lane_vec_t   idb_din_o
);

    opm_beat_if beat_if ();

    opm_ctrl ctrl_inst (
        .clk         (clk),
        .rstn        (rstn),
        .cfg_start_i (cfg_start_i),
        .cfg_stage_i (cfg_stage_i),
        .cfg_count_i (cfg_count_i),
        .cfg_m_i     (cfg_m_i),
        .cfg_n1_i    (cfg_n1_i),
        .valid_i     (valid_i),
        .act_i       (act_i),
        .acc_i       (acc_i),
        .ready_o     (ready_o),
        .finish_o    (finish_o),
        .beat        (beat_if.ctrl)
    );

    // output stream side
    opm_data_buffer ddb_inst (
        .clk      (clk),
        .rstn     (rstn),
        .tready_i (tready_i),
        .tvalid_o (tvalid_o),
        .tlast_o  (tlast_o),
        .tdata_o  (tdata_o),
        .beat     (beat_if.ddb)
    );

    opm_idb_writer idb_inst (
        .clk         (clk),
        .rstn        (rstn),
        .idb_wr_en_o (idb_wr_en_o),
        .idb_addr_o  (idb_addr_o),
        .idb_din_o   (idb_din_o),
        .beat        (beat_if.idb)
    );

endmodule

// ==== opm_idb_writer.sv ====
`timescale 1ns/1ns
`include "opm_defs.svh"

module opm_idb_writer (
    input  logic                 clk,
    input  logic                 rstn,
    output opm_pkg::lane_mask_t  idb_wr_en_o,
    output opm_pkg::idb_addr_t   idb_addr_o,
    output opm_pkg::lane_vec_t   idb_din_o,
    opm_beat_if.idb              beat
);

    opm_pkg::idb_addr_t  da_addr;
    opm_pkg::lane_mask_t da_mask;

    // dA is stored transposed, n1 picks the lane and the row block
    assign da_addr = opm_pkg::idb_addr_t'(`OPM_IDB_DA_BASE
                     + (beat.n1_idx / `OPM_NUM_PE) * `OPM_MAX_M + beat.m_idx);
    assign da_mask = opm_pkg::lane_mask_t'(1) << (beat.n1_idx % `OPM_NUM_PE);

    // write enables, zero on cycles without a beat
    always_ff @(posedge clk) begin
        if (!rstn) begin
            idb_wr_en_o <= '0;
        end else if (beat.beat_valid) begin
            case (beat.stage)
                opm_pkg::STAGE_FP,
                opm_pkg::STAGE_BPDZ: idb_wr_en_o <= '1;
                opm_pkg::STAGE_BPDA: idb_wr_en_o <= da_mask;
                default:             idb_wr_en_o <= '0;
            endcase
        end else begin
            idb_wr_en_o <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (beat.beat_valid) begin
            case (beat.stage)
                opm_pkg::STAGE_BPDA: begin
                    idb_addr_o <= da_addr;
                    idb_din_o  <= {`OPM_NUM_PE{beat.acc}};
                end
                opm_pkg::STAGE_BPDZ: begin
                    idb_addr_o <= opm_pkg::idb_addr_t'(`OPM_IDB_DZ_BASE + beat.beat_idx);
                    idb_din_o  <= beat.lanes;
                end
                default: begin
                    idb_addr_o <= opm_pkg::idb_addr_t'(`OPM_IDB_A_BASE + beat.beat_idx);
                    idb_din_o  <= beat.lanes;
                end
            endcase
        end
    end

endmodule

// ==== opm_data_buffer.sv ====
`timescale 1ns/1ns
`include "opm_defs.svh"

module opm_data_buffer (
    input  logic                clk,
    input  logic                rstn,
    input  logic                tready_i,
    output logic                tvalid_o,
    output logic                tlast_o,
    output opm_pkg::lane_vec_t  tdata_o,
    opm_beat_if.ddb             beat
);

    localparam int DEPTH = `OPM_DDB_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    opm_pkg::lane_vec_t mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     fill;

    opm_pkg::beat_cnt_t ld_cnt;
    opm_pkg::beat_cnt_t last_idx;
    logic               last_seen;

    logic               streaming;
    logic               push;
    logic               pop;
    logic               take;

    assign streaming = beat.stage inside {opm_pkg::STAGE_FP, opm_pkg::STAGE_BPDW,
                                          opm_pkg::STAGE_PU};

    assign push = beat.beat_valid && streaming;
    // refill the output register when it is empty or being taken
    assign pop  = (fill != '0) && (!tvalid_o || tready_i);
    assign take = tvalid_o && tready_i;

    assign beat.ddb_full = (fill == DEPTH[PTR_W:0]);
    assign beat.out_done = take && tlast_o;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= beat.lanes;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || beat.clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // index of the final beat, known once it has been pushed
    always_ff @(posedge clk) begin
        if (!rstn || beat.clear) begin
            last_seen <= 1'b0;
            last_idx  <= '0;
        end else if (push && beat.beat_last) begin
            last_seen <= 1'b1;
            last_idx  <= beat.beat_idx;
        end
    end

    // output register and beat counter
    always_ff @(posedge clk) begin
        if (!rstn || beat.clear) begin
            tvalid_o <= 1'b0;
            tlast_o  <= 1'b0;
            ld_cnt   <= '0;
        end else if (pop) begin
            tvalid_o <= 1'b1;
            tlast_o  <= last_seen && (ld_cnt == last_idx);
            ld_cnt   <= ld_cnt + 1'b1;
        end else if (take) begin
            tvalid_o <= 1'b0;
            tlast_o  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            tdata_o <= mem[rd_ptr];
        end
    end

    a_fill_bound: assert property (@(posedge clk) disable iff (!rstn)
        fill <= DEPTH[PTR_W:0]);

    // AXI-stream hold rule under back-pressure
    a_hold_stalled: assert property (@(posedge clk) disable iff (!rstn || beat.clear)
        (tvalid_o && !tready_i) |=> tvalid_o && $stable(tdata_o) && $stable(tlast_o));

endmodule

// ==== opm_ctrl.sv ====
`timescale 1ns/1ns

module opm_ctrl (
    input  logic                clk,
    input  logic                rstn,
    input  logic                cfg_start_i,
    input  opm_pkg::stage_t     cfg_stage_i,
    input  opm_pkg::beat_cnt_t  cfg_count_i,
    input  opm_pkg::m_cnt_t     cfg_m_i,
    input  opm_pkg::n1_cnt_t    cfg_n1_i,
    input  logic                valid_i,
    input  opm_pkg::lane_vec_t  act_i,
    input  opm_pkg::act_t       acc_i,
    output logic                ready_o,
    output logic                finish_o,
    opm_beat_if.ctrl            beat
);

    opm_pkg::opm_state_t state;
    opm_pkg::stage_t     stage_q;
    opm_pkg::beat_cnt_t  count_q;
    opm_pkg::m_cnt_t     m_q;
    opm_pkg::n1_cnt_t    n1_q;

    opm_pkg::beat_cnt_t  beat_cnt;
    opm_pkg::m_cnt_t     m_cnt;
    opm_pkg::n1_cnt_t    n1_cnt;
    logic                in_open;
    logic                streaming;
    logic                accept;
    logic                last_in;
    logic                run_done;

    // stages that leave through the output stream
    assign streaming = stage_q inside {opm_pkg::STAGE_FP, opm_pkg::STAGE_BPDW,
                                       opm_pkg::STAGE_PU};

    assign ready_o  = (state == opm_pkg::ST_RUN) && in_open && !(streaming && beat.ddb_full);
    assign accept   = valid_i && ready_o;
    assign last_in  = (beat_cnt == count_q);
    // end of run: last output taken, or last beat accepted for IDB-only stages
    assign run_done = streaming ? beat.out_done : (accept && last_in);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= opm_pkg::ST_IDLE;
            finish_o <= 1'b1;
        end else begin
            case (state)
                opm_pkg::ST_IDLE: begin
                    if (cfg_start_i && finish_o) begin
                        state    <= opm_pkg::ST_CFG;
                        finish_o <= 1'b0;
                    end
                end
                opm_pkg::ST_CFG: begin
                    state <= opm_pkg::ST_RUN;
                end
                opm_pkg::ST_RUN: begin
                    if (run_done) begin
                        state    <= opm_pkg::ST_IDLE;
                        finish_o <= 1'b1;
                    end
                end
                default: begin
                    state <= opm_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // config is held by the host, latch it when the run starts
    always_ff @(posedge clk) begin
        if (state == opm_pkg::ST_IDLE && cfg_start_i && finish_o) begin
            stage_q <= cfg_stage_i;
            count_q <= cfg_count_i;
            m_q     <= cfg_m_i;
            n1_q    <= cfg_n1_i;
        end
    end

    // input counters, m wraps at cfg m and carries into n1
    always_ff @(posedge clk) begin
        if (!rstn || state == opm_pkg::ST_CFG) begin
            beat_cnt <= '0;
            m_cnt    <= '0;
            n1_cnt   <= '0;
            in_open  <= (state == opm_pkg::ST_CFG);
        end else if (accept) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_in) begin
                in_open <= 1'b0;
            end
            if (m_cnt == m_q) begin
                m_cnt  <= '0;
                n1_cnt <= (n1_cnt == n1_q) ? '0 : n1_cnt + 1'b1;
            end else begin
                m_cnt <= m_cnt + 1'b1;
            end
        end
    end

    assign beat.beat_valid = accept;
    assign beat.stage      = stage_q;
    assign beat.lanes      = act_i;
    assign beat.acc        = acc_i;
    assign beat.beat_idx   = beat_cnt;
    assign beat.beat_last  = last_in;
    assign beat.m_idx      = m_cnt;
    assign beat.n1_idx     = n1_cnt;
    assign beat.clear      = (state == opm_pkg::ST_CFG);

    // the input window closes before the state leaves RUN
    a_ready_in_run: assert property (@(posedge clk) disable iff (!rstn)
        in_open |-> (state == opm_pkg::ST_RUN));

endmodule

// ==== opm_beat_if.sv ====
`timescale 1ns/1ns

interface opm_beat_if;

    // accepted beat and run context, from the controller
    logic                beat_valid;
    opm_pkg::stage_t     stage;
    opm_pkg::lane_vec_t  lanes;
    opm_pkg::act_t       acc;
    opm_pkg::beat_cnt_t  beat_idx;
    logic                beat_last;
    opm_pkg::m_cnt_t     m_idx;
    opm_pkg::n1_cnt_t    n1_idx;
    logic                clear;

    // buffer status back to the controller
    logic                ddb_full;
    logic                out_done;

    modport ctrl (
        output beat_valid, stage, lanes, acc, beat_idx, beat_last, m_idx, n1_idx, clear,
        input  ddb_full, out_done
    );

    modport ddb (
        input  beat_valid, stage, lanes, acc, beat_idx, beat_last, m_idx, n1_idx, clear,
        output ddb_full, out_done
    );

    modport idb (
        input  beat_valid, stage, lanes, acc, beat_idx, beat_last, m_idx, n1_idx, clear
    );

endinterface

// ==== opm_pkg.sv ====
`include "opm_defs.svh"

package opm_pkg;

    // one activation or accumulator word
    typedef logic [`OPM_ACT_BW-1:0] act_t;
    // all lanes side by side, lane 0 in the low bits
    typedef logic [`OPM_NUM_PE*`OPM_ACT_BW-1:0] lane_vec_t;
    typedef logic [`OPM_NUM_PE-1:0] lane_mask_t;

    typedef logic [`OPM_CNT_BW-1:0] beat_cnt_t;
    typedef logic [$clog2(`OPM_MAX_M)-1:0] m_cnt_t;
    typedef logic [$clog2(`OPM_MAX_N)-1:0] n1_cnt_t;
    typedef logic [`OPM_IDB_AW-1:0] idb_addr_t;

    // training stage of a run
    typedef enum logic [2:0] {
        STAGE_FP,
        STAGE_BPDZ,
        STAGE_BPDA,
        STAGE_BPDW,
        STAGE_PU
    } stage_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CFG,
        ST_RUN
    } opm_state_t;

endpackage

// ==== opm_defs.svh ====
`ifndef OPM_DEFS_SVH
`define OPM_DEFS_SVH

// lane count and value width
`define OPM_NUM_PE      4
`define OPM_ACT_BW      16

// largest m and n of a layer
`define OPM_MAX_M       8
`define OPM_MAX_N       32

// DRAM data buffer entries
`define OPM_DDB_DEPTH   8

// beat counter, wide enough for MAX_M*MAX_N
`define OPM_CNT_BW      8

// IDB holds MAX_M*MAX_N/NUM_PE words per region, two regions
`define OPM_IDB_AW      7

// IDB region bases
`define OPM_IDB_A_BASE  0
`define OPM_IDB_DZ_BASE 0
`define OPM_IDB_DA_BASE 64

`endif
